//--- hdl/platform_pkg.sv
/* Shared widths, AXI response codes, IO address map, control FSM states
   and the byte-lane write merge */

package platform_pkg;

    localparam int XLEN = 32;

    typedef logic [XLEN-1:0]     addr_t;
    typedef logic [XLEN-1:0]     data_t;
    typedef logic [XLEN/8-1:0]   strb_t;
    typedef logic [1:0]          resp_t;
    typedef logic [2*XLEN-1:0]   mtime_t;

    localparam resp_t RESP_OKAY   = 2'd0;
    localparam resp_t RESP_DECERR = 2'd3;

    ////////////////////
    // IO window map, offsets from IO_BASE
    localparam addr_t GPIO_OFS   = 32'h0000_0000;
    localparam addr_t GPIO_SIZE  = 32'd8;
    localparam addr_t CLINT_OFS  = 32'h0000_0018;
    localparam addr_t CLINT_SIZE = 32'd20;

    // GPIO registers
    localparam addr_t GPIO_OUT_REG = 32'd0;
    localparam addr_t GPIO_IN_REG  = 32'd4;

    // CLINT registers
    localparam addr_t MSIP_REG        = 32'd0;
    localparam addr_t MTIME_LO_REG    = 32'd4;
    localparam addr_t MTIME_HI_REG    = 32'd8;
    localparam addr_t MTIMECMP_LO_REG = 32'd12;
    localparam addr_t MTIMECMP_HI_REG = 32'd16;

    typedef enum logic [1:0] {
        IDLE,
        ACCESS,
        RESP
    } ctrl_state_t;

    // Merge write data into a word, enabled bytes only
    function automatic data_t apply_strb(data_t old_val, data_t new_val, strb_t strb);
        data_t res;
        res = old_val;
        for (int i = 0; i < XLEN/8; i++) begin
            if (strb[i]) begin
                res[8*i +: 8] = new_val[8*i +: 8];
            end
        end
        return res;
    endfunction

endpackage

//--- hdl/reg_bus_if.sv
/* Single-cycle register access bus with master and slave modports */

`timescale 1ns/1ns

interface reg_bus_if;
    import platform_pkg::*;

    // One-cycle strobe, rdata/err answer in the same cycle
    logic  req;
    logic  wr;
    addr_t addr;
    data_t wdata;
    strb_t wstrb;
    data_t rdata;
    // No register at addr
    logic  err;

    modport master (
        output req, wr, addr, wdata, wstrb,
        input  rdata, err
    );

    modport slave (
        input  req, wr, addr, wdata, wstrb,
        output rdata, err
    );

endinterface

//--- hdl/axil_slave_ctrl.sv
/* AXI4-lite slave control FSM, one transaction at a time,
   turned into a single register bus access */

`timescale 1ns/1ns

module axil_slave_ctrl (
    input  logic                aclk,
    input  logic                arst_n,
    // Write address and data
    input  logic                awvalid,
    output logic                awready,
    input  platform_pkg::addr_t awaddr,
    input  logic                wvalid,
    output logic                wready,
    input  platform_pkg::data_t wdata,
    input  platform_pkg::strb_t wstrb,
    // Write response
    output logic                bvalid,
    input  logic                bready,
    output platform_pkg::resp_t bresp,
    // Read address
    input  logic                arvalid,
    output logic                arready,
    input  platform_pkg::addr_t araddr,
    // Read data
    output logic                rvalid,
    input  logic                rready,
    output platform_pkg::data_t rdata,
    output platform_pkg::resp_t rresp,
    // Register side
    reg_bus_if.master           bus
);
    import platform_pkg::*;

    ctrl_state_t state;
    logic        wr_accept;
    logic        rd_accept;

    // Latched request
    logic        wr_q;
    addr_t       addr_q;
    data_t       wdata_q;
    strb_t       wstrb_q;

    // Latched answer
    data_t       rdata_q;
    resp_t       resp_q;

    ////////////////////
    // Handshakes

    // Address and data taken together, writes win over reads
    assign wr_accept = (state == IDLE) && awvalid && wvalid;
    assign awready   = wr_accept;
    assign wready    = wr_accept;

    assign arready   = (state == IDLE) && !awvalid && !wvalid;
    assign rd_accept = arready && arvalid;

    ////////////////////
    // FSM

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            state  <= IDLE;
            bvalid <= 1'b0;
            rvalid <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (wr_accept || rd_accept) begin
                        state <= ACCESS;
                    end
                end
                ACCESS: begin
                    state <= RESP;
                end
                RESP: begin
                    // Response goes out one cycle into RESP, held until taken
                    if (bvalid && bready) begin
                        bvalid <= 1'b0;
                        state  <= IDLE;
                    end else if (rvalid && rready) begin
                        rvalid <= 1'b0;
                        state  <= IDLE;
                    end else if (!bvalid && !rvalid) begin
                        bvalid <= wr_q;
                        rvalid <= !wr_q;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    ////////////////////
    // Payload

    always_ff @(posedge aclk) begin
        if (wr_accept) begin
            wr_q    <= 1'b1;
            addr_q  <= awaddr;
            wdata_q <= wdata;
            wstrb_q <= wstrb;
        end else if (rd_accept) begin
            wr_q    <= 1'b0;
            addr_q  <= araddr;
        end

        // Sample the combinational answer during the access cycle
        if (state == ACCESS) begin
            rdata_q <= bus.rdata;
            resp_q  <= bus.err ? RESP_DECERR : RESP_OKAY;
        end
    end

    assign bus.req   = (state == ACCESS);
    assign bus.wr    = wr_q;
    assign bus.addr  = addr_q;
    assign bus.wdata = wdata_q;
    assign bus.wstrb = wstrb_q;

    assign bresp = resp_q;
    assign rresp = resp_q;
    assign rdata = rdata_q;

endmodule

//--- hdl/io_addr_decode.sv
/* IO window decoder, routes the request to GPIO or CLINT
   and merges read data and error back */

`timescale 1ns/1ns

module io_addr_decode #(
    parameter platform_pkg::addr_t IO_BASE = 32'h0010_0000
) (
    reg_bus_if.slave  cpu,
    reg_bus_if.master gpio,
    reg_bus_if.master clint
);
    import platform_pkg::*;

    logic  in_io;
    addr_t io_ofs;
    addr_t gpio_ofs;
    addr_t clint_ofs;
    logic  gpio_hit;
    logic  clint_hit;

    // Offsets wrap below their base, so one compare per window
    assign in_io     = (cpu.addr >= IO_BASE);
    assign io_ofs    = cpu.addr - IO_BASE;
    assign gpio_ofs  = io_ofs - GPIO_OFS;
    assign clint_ofs = io_ofs - CLINT_OFS;

    assign gpio_hit  = in_io && (gpio_ofs < GPIO_SIZE);
    assign clint_hit = in_io && (clint_ofs < CLINT_SIZE);

    ////////////////////
    // Requests out

    assign gpio.req   = cpu.req && gpio_hit;
    assign gpio.wr    = cpu.wr;
    assign gpio.addr  = gpio_ofs;
    assign gpio.wdata = cpu.wdata;
    assign gpio.wstrb = cpu.wstrb;

    assign clint.req   = cpu.req && clint_hit;
    assign clint.wr    = cpu.wr;
    assign clint.addr  = clint_ofs;
    assign clint.wdata = cpu.wdata;
    assign clint.wstrb = cpu.wstrb;

    ////////////////////
    // Answer back, unmapped reads as zero with error

    always_comb begin
        if (gpio_hit) begin
            cpu.rdata = gpio.rdata;
            cpu.err   = gpio.err;
        end else if (clint_hit) begin
            cpu.rdata = clint.rdata;
            cpu.err   = clint.err;
        end else begin
            cpu.rdata = '0;
            cpu.err   = 1'b1;
        end
    end

endmodule

//--- hdl/gpio_regs.sv
/* GPIO output register with byte writes and input readback */

`timescale 1ns/1ns

module gpio_regs (
    input  logic                aclk,
    input  logic                arst_n,
    reg_bus_if.slave            bus,
    input  platform_pkg::data_t gpio_in,
    output platform_pkg::data_t gpio_out
);
    import platform_pkg::*;

    logic out_wr;

    assign out_wr = bus.req && bus.wr && (bus.addr == GPIO_OUT_REG);

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            gpio_out <= '0;
        end else if (out_wr) begin
            gpio_out <= apply_strb(gpio_out, bus.wdata, bus.wstrb);
        end
    end

    // Read mux, GPIO_IN_REG is read-only and drops writes silently
    always_comb begin
        bus.rdata = '0;
        bus.err   = 1'b0;
        case (bus.addr)
            GPIO_OUT_REG: begin
                bus.rdata = gpio_out;
            end
            GPIO_IN_REG: begin
                bus.rdata = gpio_in;
            end
            default: begin
                bus.err = 1'b1;
            end
        endcase
    end

endmodule

//--- hdl/clint_timer.sv
/* CLINT with rtc synchronizer, mtime counter, mtimecmp, msip
   and the software and timer interrupts */

`timescale 1ns/1ns

module clint_timer #(
    parameter int RTC_SYNC_STAGES = 2
) (
    input  logic     aclk,
    input  logic     arst_n,
    input  logic     rtc,
    reg_bus_if.slave bus,
    output logic     sw_irq,
    output logic     timer_irq
);
    import platform_pkg::*;

    logic [RTC_SYNC_STAGES-1:0] rtc_sync;
    logic                       rtc_prev;
    logic                       rtc_rise;

    logic   wr_en;
    logic   msip;
    mtime_t mtime;
    mtime_t mtimecmp;

    ////////////////////
    // rtc into aclk domain

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            rtc_sync <= '0;
            rtc_prev <= 1'b0;
        end else begin
            rtc_sync[0] <= rtc;
            for (int i = 1; i < RTC_SYNC_STAGES; i++) begin
                rtc_sync[i] <= rtc_sync[i-1];
            end
            rtc_prev <= rtc_sync[RTC_SYNC_STAGES-1];
        end
    end

    assign rtc_rise = rtc_sync[RTC_SYNC_STAGES-1] && !rtc_prev;

    ////////////////////
    // Registers

    assign wr_en = bus.req && bus.wr;

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            msip <= 1'b0;
        end else if (wr_en && (bus.addr == MSIP_REG) && bus.wstrb[0]) begin
            msip <= bus.wdata[0];
        end
    end

    // Bus write beats the rtc tick in the same cycle
    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            mtime <= '0;
        end else if (wr_en && (bus.addr == MTIME_LO_REG)) begin
            mtime[XLEN-1:0] <= apply_strb(mtime[XLEN-1:0], bus.wdata, bus.wstrb);
        end else if (wr_en && (bus.addr == MTIME_HI_REG)) begin
            mtime[2*XLEN-1:XLEN] <= apply_strb(mtime[2*XLEN-1:XLEN], bus.wdata, bus.wstrb);
        end else if (rtc_rise) begin
            mtime <= mtime + mtime_t'(1);
        end
    end

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            mtimecmp <= '1;
        end else if (wr_en && (bus.addr == MTIMECMP_LO_REG)) begin
            mtimecmp[XLEN-1:0] <= apply_strb(mtimecmp[XLEN-1:0], bus.wdata, bus.wstrb);
        end else if (wr_en && (bus.addr == MTIMECMP_HI_REG)) begin
            mtimecmp[2*XLEN-1:XLEN] <= apply_strb(mtimecmp[2*XLEN-1:XLEN], bus.wdata,
                                                  bus.wstrb);
        end
    end

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            timer_irq <= 1'b0;
        end else begin
            timer_irq <= (mtime >= mtimecmp);
        end
    end

    assign sw_irq = msip;

    ////////////////////
    // Read mux

    always_comb begin
        bus.rdata = '0;
        bus.err   = 1'b0;
        case (bus.addr)
            MSIP_REG:        bus.rdata = {{(XLEN-1){1'b0}}, msip};
            MTIME_LO_REG:    bus.rdata = mtime[XLEN-1:0];
            MTIME_HI_REG:    bus.rdata = mtime[2*XLEN-1:XLEN];
            MTIMECMP_LO_REG: bus.rdata = mtimecmp[XLEN-1:0];
            MTIMECMP_HI_REG: bus.rdata = mtimecmp[2*XLEN-1:XLEN];
            default:         bus.err   = 1'b1;
        endcase
    end

endmodule

//--- hdl/io_platform_top.sv
/* IO platform top, AXI4-lite slave port to GPIO and CLINT */

`timescale 1ns/1ns

module io_platform_top #(
    parameter platform_pkg::addr_t IO_BASE         = 32'h0010_0000,
    parameter int                  RTC_SYNC_STAGES = 2
) (
    input  logic                aclk,
    input  logic                arst_n,
    // Real-time reference
    input  logic                rtc,
    // AXI4-lite slave
    input  logic                slv_awvalid,
    output logic                slv_awready,
    input  platform_pkg::addr_t slv_awaddr,
    input  logic                slv_wvalid,
    output logic                slv_wready,
    input  platform_pkg::data_t slv_wdata,
    input  platform_pkg::strb_t slv_wstrb,
    output logic                slv_bvalid,
    input  logic                slv_bready,
    output platform_pkg::resp_t slv_bresp,
    input  logic                slv_arvalid,
    output logic                slv_arready,
    input  platform_pkg::addr_t slv_araddr,
    output logic                slv_rvalid,
    input  logic                slv_rready,
    output platform_pkg::data_t slv_rdata,
    output platform_pkg::resp_t slv_rresp,
    // GPIO pins and interrupts
    input  platform_pkg::data_t gpio_in,
    output platform_pkg::data_t gpio_out,
    output logic                sw_irq,
    output logic                timer_irq
);

    reg_bus_if cpu_bus ();
    reg_bus_if gpio_bus ();
    reg_bus_if clint_bus ();

    axil_slave_ctrl u_ctrl (
        .aclk    (aclk),
        .arst_n  (arst_n),
        .awvalid (slv_awvalid),
        .awready (slv_awready),
        .awaddr  (slv_awaddr),
        .wvalid  (slv_wvalid),
        .wready  (slv_wready),
        .wdata   (slv_wdata),
        .wstrb   (slv_wstrb),
        .bvalid  (slv_bvalid),
        .bready  (slv_bready),
        .bresp   (slv_bresp),
        .arvalid (slv_arvalid),
        .arready (slv_arready),
        .araddr  (slv_araddr),
        .rvalid  (slv_rvalid),
        .rready  (slv_rready),
        .rdata   (slv_rdata),
        .rresp   (slv_rresp),
        .bus     (cpu_bus.master)
    );

    io_addr_decode #(
        .IO_BASE (IO_BASE)
    ) u_decode (
        .cpu   (cpu_bus.slave),
        .gpio  (gpio_bus.master),
        .clint (clint_bus.master)
    );

    gpio_regs u_gpio (
        .aclk     (aclk),
        .arst_n   (arst_n),
        .bus      (gpio_bus.slave),
        .gpio_in  (gpio_in),
        .gpio_out (gpio_out)
    );

    clint_timer #(
        .RTC_SYNC_STAGES (RTC_SYNC_STAGES)
    ) u_clint (
        .aclk      (aclk),
        .arst_n    (arst_n),
        .rtc       (rtc),
        .bus       (clint_bus.slave),
        .sw_irq    (sw_irq),
        .timer_irq (timer_irq)
    );

endmodule

//--- verif/io_platform_tb.sv
/* Testbench for the IO platform with AXI4-lite bus tasks, register model,
   reference read function and response checker */

`timescale 1ns/1ns

module io_platform_tb;
    import platform_pkg::*;

    localparam addr_t IO_BASE         = 32'h0010_0000;
    localparam int    RTC_SYNC_STAGES = 2;
    localparam int    WAIT_LIMIT      = 50;

    localparam addr_t GPIO_OUT_ADDR    = IO_BASE + GPIO_OFS + GPIO_OUT_REG;
    localparam addr_t GPIO_IN_ADDR     = IO_BASE + GPIO_OFS + GPIO_IN_REG;
    localparam addr_t MSIP_ADDR        = IO_BASE + CLINT_OFS + MSIP_REG;
    localparam addr_t MTIME_LO_ADDR    = IO_BASE + CLINT_OFS + MTIME_LO_REG;
    localparam addr_t MTIME_HI_ADDR    = IO_BASE + CLINT_OFS + MTIME_HI_REG;
    localparam addr_t MTIMECMP_LO_ADDR = IO_BASE + CLINT_OFS + MTIMECMP_LO_REG;
    localparam addr_t MTIMECMP_HI_ADDR = IO_BASE + CLINT_OFS + MTIMECMP_HI_REG;

    logic  aclk;
    logic  arst_n;
    logic  rtc;
    logic  slv_awvalid;
    logic  slv_awready;
    addr_t slv_awaddr;
    logic  slv_wvalid;
    logic  slv_wready;
    data_t slv_wdata;
    strb_t slv_wstrb;
    logic  slv_bvalid;
    logic  slv_bready;
    resp_t slv_bresp;
    logic  slv_arvalid;
    logic  slv_arready;
    addr_t slv_araddr;
    logic  slv_rvalid;
    logic  slv_rready;
    data_t slv_rdata;
    resp_t slv_rresp;
    data_t gpio_in;
    data_t gpio_out;
    logic  sw_irq;
    logic  timer_irq;

    // Register model
    data_t  m_gpio_out;
    data_t  m_gpio_in;
    logic   m_msip;
    mtime_t m_mtime;
    mtime_t m_mtimecmp;
    int     rtc_edges;

    // Expected responses in issue order
    data_t exp_rdata_q[$];
    resp_t exp_rresp_q[$];
    resp_t exp_bresp_q[$];

    logic  aw_fire;
    logic  ar_fire;
    int    errors;
    int    timeouts;

    io_platform_top #(
        .IO_BASE         (IO_BASE),
        .RTC_SYNC_STAGES (RTC_SYNC_STAGES)
    ) dut0 (.*);

    initial aclk = 1'b0;
    always #50 aclk = ~aclk;

    // Handshakes as seen by the DUT at the rising edge
    always @(posedge aclk) begin
        aw_fire <= slv_awvalid && slv_awready && slv_wvalid && slv_wready;
        ar_fire <= slv_arvalid && slv_arready;
    end

    task automatic check_value(input string name, input data_t exp_val, input data_t act_val);
        assert (act_val === exp_val) else begin
            $display("ERROR at %0t ns: %s expected %h, got %h", $time, name, exp_val, act_val);
            errors++;
        end
    endtask

    ////////////////////
    // Reference model

    function automatic data_t merge_bytes(data_t old_val, data_t new_val, strb_t strb);
        data_t mask;
        mask = {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
        return (old_val & ~mask) | (new_val & mask);
    endfunction

    function automatic void expected_read(input addr_t addr, output data_t data,
                                          output resp_t resp);
        addr_t ofs;
        ofs  = addr - IO_BASE;
        data = '0;
        resp = RESP_OKAY;
        if (addr < IO_BASE) begin
            resp = RESP_DECERR;
        end else begin
            case (ofs)
                GPIO_OFS + GPIO_OUT_REG:     data = m_gpio_out;
                GPIO_OFS + GPIO_IN_REG:      data = m_gpio_in;
                CLINT_OFS + MSIP_REG:        data = {31'd0, m_msip};
                CLINT_OFS + MTIME_LO_REG:    data = m_mtime[31:0];
                CLINT_OFS + MTIME_HI_REG:    data = m_mtime[63:32];
                CLINT_OFS + MTIMECMP_LO_REG: data = m_mtimecmp[31:0];
                CLINT_OFS + MTIMECMP_HI_REG: data = m_mtimecmp[63:32];
                default:                     resp = RESP_DECERR;
            endcase
        end
    endfunction

    function automatic void model_write(input addr_t addr, input data_t data, input strb_t strb);
        addr_t ofs;
        ofs = addr - IO_BASE;
        if (addr >= IO_BASE) begin
            case (ofs)
                GPIO_OFS + GPIO_OUT_REG: m_gpio_out = merge_bytes(m_gpio_out, data, strb);
                CLINT_OFS + MSIP_REG: begin
                    if (strb[0]) begin
                        m_msip = data[0];
                    end
                end
                CLINT_OFS + MTIME_LO_REG:
                    m_mtime[31:0] = merge_bytes(m_mtime[31:0], data, strb);
                CLINT_OFS + MTIME_HI_REG:
                    m_mtime[63:32] = merge_bytes(m_mtime[63:32], data, strb);
                CLINT_OFS + MTIMECMP_LO_REG:
                    m_mtimecmp[31:0] = merge_bytes(m_mtimecmp[31:0], data, strb);
                CLINT_OFS + MTIMECMP_HI_REG:
                    m_mtimecmp[63:32] = merge_bytes(m_mtimecmp[63:32], data, strb);
                default: ;
            endcase
        end
    endfunction

    ////////////////////
    // Response checker

    always @(posedge aclk) begin
        if (slv_rvalid && slv_rready) begin
            assert (exp_rdata_q.size() > 0) else begin
                $display("read response at %0t ns with no read outstanding", $time);
                errors++;
            end
            if (exp_rdata_q.size() > 0) begin
                check_value("slv_rdata", exp_rdata_q.pop_front(), slv_rdata);
                check_value("slv_rresp", data_t'(exp_rresp_q.pop_front()), data_t'(slv_rresp));
            end
        end
        if (slv_bvalid && slv_bready) begin
            assert (exp_bresp_q.size() > 0) else begin
                $display("write response at %0t ns with no write outstanding", $time);
                errors++;
            end
            if (exp_bresp_q.size() > 0) begin
                check_value("slv_bresp", data_t'(exp_bresp_q.pop_front()), data_t'(slv_bresp));
            end
        end
    end

    ////////////////////
    // Bus access tasks

    // Queue the expected response, update the model and present the write
    task automatic start_write(input addr_t addr, input data_t data, input strb_t strb);
        data_t exp_data;
        resp_t exp_resp;
        expected_read(addr, exp_data, exp_resp);
        exp_bresp_q.push_back(exp_resp);
        model_write(addr, data, strb);
        slv_awvalid = 1'b1;
        slv_awaddr  = addr;
        slv_wvalid  = 1'b1;
        slv_wdata   = data;
        slv_wstrb   = strb;
    endtask

    // Wait for the accept, then take the response after hold cycles
    task automatic finish_write(input addr_t addr, input int hold);
        int    n;
        resp_t held_resp;
        n = 0;
        do begin
            @(negedge aclk);
            n++;
        end while (!aw_fire && n < WAIT_LIMIT);
        slv_awvalid = 1'b0;
        slv_wvalid  = 1'b0;
        if (!aw_fire) begin
            $display("timeout: write to %h not accepted within %0d cycles", addr, WAIT_LIMIT);
            timeouts++;
            return;
        end
        n = 0;
        while (!slv_bvalid && n < WAIT_LIMIT) begin
            @(negedge aclk);
            n++;
        end
        if (!slv_bvalid) begin
            $display("timeout: no bvalid within %0d cycles for write to %h", WAIT_LIMIT, addr);
            timeouts++;
            return;
        end
        // bvalid rises two edges after the accept edge
        check_value("slv_bvalid cycles after accept", data_t'(2), data_t'(n));
        held_resp = slv_bresp;
        // Response must sit still under back-pressure
        for (int i = 0; i < hold; i++) begin
            @(negedge aclk);
            check_value("slv_bvalid", data_t'(1'b1), data_t'(slv_bvalid));
            check_value("slv_bresp", data_t'(held_resp), data_t'(slv_bresp));
            check_value("slv_arready", '0, data_t'(slv_arready));
        end
        slv_bready = 1'b1;
        @(negedge aclk);
        slv_bready = 1'b0;
        check_value("slv_bvalid", '0, data_t'(slv_bvalid));
    endtask

    task automatic axi_write(input addr_t addr, input data_t data, input strb_t strb,
                             input int hold);
        if (timeouts != 0) return;
        @(negedge aclk);
        start_write(addr, data, strb);
        finish_write(addr, hold);
    endtask

    task automatic axi_read(input addr_t addr, output data_t rd, input int hold);
        int    n;
        data_t exp_data;
        resp_t exp_resp;
        data_t held_data;
        resp_t held_resp;
        rd = '0;
        if (timeouts != 0) return;
        expected_read(addr, exp_data, exp_resp);
        exp_rdata_q.push_back(exp_data);
        exp_rresp_q.push_back(exp_resp);
        @(negedge aclk);
        slv_arvalid = 1'b1;
        slv_araddr  = addr;
        n = 0;
        do begin
            @(negedge aclk);
            n++;
        end while (!ar_fire && n < WAIT_LIMIT);
        slv_arvalid = 1'b0;
        if (!ar_fire) begin
            $display("timeout: read of %h not accepted within %0d cycles", addr, WAIT_LIMIT);
            timeouts++;
            return;
        end
        n = 0;
        while (!slv_rvalid && n < WAIT_LIMIT) begin
            @(negedge aclk);
            n++;
        end
        if (!slv_rvalid) begin
            $display("timeout: no rvalid within %0d cycles for read of %h", WAIT_LIMIT, addr);
            timeouts++;
            return;
        end
        check_value("slv_rvalid cycles after accept", data_t'(2), data_t'(n));
        held_data = slv_rdata;
        held_resp = slv_rresp;
        rd        = held_data;
        // A write presented during back-pressure waits for the read response
        if (hold > 0) begin
            start_write(GPIO_OUT_ADDR, $urandom, strb_t'($urandom));
        end
        for (int i = 0; i < hold; i++) begin
            @(negedge aclk);
            check_value("slv_rvalid", data_t'(1'b1), data_t'(slv_rvalid));
            check_value("slv_rdata", held_data, slv_rdata);
            check_value("slv_rresp", data_t'(held_resp), data_t'(slv_rresp));
            check_value("slv_awready", '0, data_t'(slv_awready));
            check_value("slv_wready", '0, data_t'(slv_wready));
        end
        slv_rready = 1'b1;
        @(negedge aclk);
        slv_rready = 1'b0;
        check_value("slv_rvalid", '0, data_t'(slv_rvalid));
        if (hold > 0) begin
            finish_write(GPIO_OUT_ADDR, 0);
        end
    endtask

    // One rtc period of 16 aclk cycles
    task automatic rtc_pulse();
        if (timeouts != 0) return;
        @(negedge aclk);
        rtc = 1'b1;
        repeat (8) @(negedge aclk);
        rtc       = 1'b0;
        m_mtime   = m_mtime + 64'd1;
        rtc_edges = rtc_edges + 1;
        repeat (8) @(negedge aclk);
    endtask

    task automatic wait_timer_irq(input logic level);
        int n;
        if (timeouts != 0) return;
        n = 0;
        while (timer_irq !== level && n < 3) begin
            @(negedge aclk);
            n++;
        end
        check_value("timer_irq", data_t'(level), data_t'(timer_irq));
    endtask

    ////////////////////
    // Test sequence

    initial begin
        data_t rd;
        int    hold;
        addr_t bad_addr [6];

        void'($urandom(18));
        arst_n      = 1'b0;
        rtc         = 1'b0;
        slv_awvalid = 1'b0;
        slv_awaddr  = '0;
        slv_wvalid  = 1'b0;
        slv_wdata   = '0;
        slv_wstrb   = '0;
        slv_bready  = 1'b0;
        slv_arvalid = 1'b0;
        slv_araddr  = '0;
        slv_rready  = 1'b0;
        gpio_in     = '0;
        m_gpio_out  = '0;
        m_gpio_in   = '0;
        m_msip      = 1'b0;
        m_mtime     = '0;
        m_mtimecmp  = '1;
        rtc_edges   = 0;
        errors      = 0;
        timeouts    = 0;
        bad_addr    = '{IO_BASE - 32'd4, IO_BASE + 32'h08, IO_BASE + 32'h10,
                        IO_BASE + 32'h14, IO_BASE + 32'h2C, IO_BASE + 32'h1000};
        repeat (3) @(negedge aclk);
        arst_n = 1'b1;

        // Reset state
        check_value("gpio_out", '0, gpio_out);
        check_value("sw_irq", '0, data_t'(sw_irq));
        check_value("timer_irq", '0, data_t'(timer_irq));
        axi_read(MTIMECMP_LO_ADDR, rd, 0);
        axi_read(MTIMECMP_HI_ADDR, rd, 0);

        // GPIO output with byte strobes
        for (int i = 0; i < 12; i++) begin
            axi_write(GPIO_OUT_ADDR, $urandom, strb_t'($urandom), 0);
            check_value("gpio_out", m_gpio_out, gpio_out);
            axi_read(GPIO_OUT_ADDR, rd, 0);
        end

        // GPIO input readback and a dropped write
        for (int i = 0; i < 4; i++) begin
            @(negedge aclk);
            gpio_in   = $urandom;
            m_gpio_in = gpio_in;
            axi_read(GPIO_IN_ADDR, rd, 0);
        end
        axi_write(GPIO_IN_ADDR, $urandom, 4'hF, 0);
        axi_read(GPIO_OUT_ADDR, rd, 0);

        // Unmapped addresses
        for (int i = 0; i < 6; i++) begin
            axi_write(bad_addr[i], $urandom, 4'hF, 0);
            axi_read(bad_addr[i], rd, 0);
        end
        axi_read(GPIO_OUT_ADDR, rd, 0);
        axi_read(MSIP_ADDR, rd, 0);
        axi_read(MTIME_LO_ADDR, rd, 0);
        axi_read(MTIMECMP_LO_ADDR, rd, 0);
        axi_read(MTIMECMP_HI_ADDR, rd, 0);
        check_value("gpio_out", m_gpio_out, gpio_out);

        // Software interrupt
        axi_write(MSIP_ADDR, 32'd1, 4'hF, 0);
        check_value("sw_irq", data_t'(1'b1), data_t'(sw_irq));
        axi_write(MSIP_ADDR, 32'd0, 4'hF, 0);
        check_value("sw_irq", '0, data_t'(sw_irq));

        // mtime follows rtc
        axi_write(MTIME_LO_ADDR, 32'd0, 4'hF, 0);
        axi_write(MTIME_HI_ADDR, 32'd0, 4'hF, 0);
        rtc_edges = 0;
        repeat ($urandom_range(8, 3)) rtc_pulse();
        axi_read(MTIME_LO_ADDR, rd, 0);
        check_value("mtime low word", data_t'(rtc_edges), rd);
        axi_read(MTIME_HI_ADDR, rd, 0);
        check_value("mtime high word", '0, rd);

        // Timer compare at equal, below and far above mtime
        axi_write(MTIMECMP_HI_ADDR, 32'd0, 4'hF, 0);
        axi_write(MTIMECMP_LO_ADDR, data_t'(rtc_edges), 4'hF, 0);
        wait_timer_irq(1'b1);
        axi_write(MTIMECMP_HI_ADDR, 32'd1, 4'hF, 0);
        wait_timer_irq(1'b0);
        axi_write(MTIMECMP_LO_ADDR, data_t'(rtc_edges - 2), 4'hF, 0);
        axi_write(MTIMECMP_HI_ADDR, 32'd0, 4'hF, 0);
        wait_timer_irq(1'b1);
        axi_write(MTIMECMP_HI_ADDR, 32'h8000_0000, 4'hF, 0);
        wait_timer_irq(1'b0);

        // Back-pressure on both response channels
        for (int i = 0; i < 6; i++) begin
            hold = $urandom_range(6, 1);
            axi_write(GPIO_OUT_ADDR, $urandom, strb_t'($urandom), hold);
            hold = $urandom_range(6, 1);
            axi_read(GPIO_OUT_ADDR, rd, hold);
            hold = $urandom_range(6, 1);
            axi_read(bad_addr[i], rd, hold);
            axi_write(bad_addr[i], $urandom, 4'hF, $urandom_range(6, 1));
        end
        axi_read(MTIME_LO_ADDR, rd, 3);
        check_value("gpio_out", m_gpio_out, gpio_out);

        check_value("pending read responses", '0, data_t'(exp_rdata_q.size()));
        check_value("pending write responses", '0, data_t'(exp_bresp_q.size()));
        $display("errors: %0d, timeouts: %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

//--- files.f
hdl/platform_pkg.sv
hdl/reg_bus_if.sv
hdl/axil_slave_ctrl.sv
hdl/io_addr_decode.sv
hdl/gpio_regs.sv
hdl/clint_timer.sv
hdl/io_platform_top.sv
verif/io_platform_tb.sv

//--- Makefile
# Verilator build and run of the IO platform testbench

VERILATOR ?= verilator
TOP       ?= io_platform_tb
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ns

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "test passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
